// File: hdl/aes_128_core.sv
// Pipelined AES-128 encryption core
// Accepts a plaintext and key every cycle and returns the ciphertext
// LATENCY cycles later, with a valid bit travelling alongside

`timescale 1ns/100ps

module aes_128_core
    import aes_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    input  block_t plaintext,
    input  block_t key,
    output logic   out_valid,
    output block_t ciphertext
);

    block_t             state_q;
    block_t             key_q;
    block_t             state_chain [0:NUM_ROUNDS-1];
    block_t             key_chain   [0:NUM_ROUNDS-1];
    block_t             round_keys  [0:NUM_ROUNDS-1];
    logic [LATENCY-1:0] valid_sr;
    logic [4:0]         settle_cnt;

    //////////////////////////////////////////////////////////////////////
    // Input register with the initial AddRoundKey
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        state_q <= plaintext ^ key;
        key_q   <= key;
    end

    assign state_chain[0] = state_q;
    assign key_chain[0]   = key_q;

    //////////////////////////////////////////////////////////////////////
    // Key schedule, one stage per round
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < NUM_ROUNDS; k++)
    begin : g_key
        if (k < NUM_ROUNDS - 1)
        begin : g_mid
            aes_key_stage #(.STAGE(k)) key_i (
                .clk       (clk),
                .key_in    (key_chain[k]),
                .round_key (round_keys[k]),
                .next_key  (key_chain[k+1])
            );
        end
        else
        begin : g_last
            // No successor for the last key
            aes_key_stage #(.STAGE(k)) key_i (
                .clk       (clk),
                .key_in    (key_chain[k]),
                .round_key (round_keys[k]),
                .next_key  ()
            );
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < NUM_ROUNDS - 1; k++)
    begin : g_round
        aes_round round_i (
            .clk       (clk),
            .state_in  (state_chain[k]),
            .round_key (round_keys[k]),
            .state_out (state_chain[k+1])
        );
    end

    aes_final_round final_i (
        .clk       (clk),
        .state_in  (state_chain[NUM_ROUNDS-1]),
        .round_key (round_keys[NUM_ROUNDS-1]),
        .state_out (ciphertext)
    );

    // Valid bit shadows the data registers one for one
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_sr <= '0;
        end
        else
        begin
            valid_sr <= {valid_sr[LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = valid_sr[LATENCY-1];

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Cycles since reset, saturating once the pipe holds no pre-reset data
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            settle_cnt <= '0;
        end
        else if (settle_cnt != 5'(LATENCY))
        begin
            settle_cnt <= settle_cnt + 1'b1;
        end
    end

    a_out_valid_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(out_valid)
    );

    // Valid leaves exactly LATENCY cycles after it entered
    a_valid_latency: assert property (
        @(posedge clk) disable iff (rst)
        settle_cnt == 5'(LATENCY) |-> out_valid == $past(in_valid, LATENCY)
    );

endmodule

// File: hdl/aes_final_round.sv
// AES final round
// SubBytes, ShiftRows and AddRoundKey without MixColumns, two cycles

`timescale 1ns/100ps

module aes_final_round
    import aes_pkg::*;
(
    input  logic   clk,
    input  block_t state_in,
    input  block_t round_key,
    output block_t state_out
);

    block_t sub_q;
    block_t shifted;

    for (genvar c = 0; c < NUM_COLS; c++)
    begin : g_sub
        aes_sbox_word sbox_i (
            .clk      (clk),
            .word_in  (state_in[c]),
            .word_out (sub_q[c])
        );
    end

    // ShiftRows as pure byte selection
    always_comb
    begin
        for (int c = 0; c < NUM_COLS; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted[c][31 - 8 * r -: 8] = sub_q[(c + r) % NUM_COLS][31 - 8 * r -: 8];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        state_out <= shifted ^ round_key;
    end

endmodule

// File: hdl/aes_key_stage.sv
// AES-128 key expansion stage
// Derives one round key from the previous key over two cycles,
// in step with the data round that consumes it

`timescale 1ns/100ps

module aes_key_stage
    import aes_pkg::*;
#(
    parameter int STAGE = 0
)
(
    input  logic   clk,
    input  block_t key_in,
    output block_t round_key,
    output block_t next_key
);

    block_t chain;
    block_t chain_q;
    word_t  rot_word;
    word_t  sub_word;

    //////////////////////////////////////////////////////////////////////
    // First cycle: word chain and SubWord lookup
    //////////////////////////////////////////////////////////////////////

    // Running XOR of the key words, rcon folded into the first
    always_comb
    begin
        chain[0] = key_in[0] ^ {RCON[STAGE], 24'h000000};
        for (int i = 1; i < NUM_COLS; i++)
        begin
            chain[i] = chain[i-1] ^ key_in[i];
        end
    end

    always_ff @(posedge clk)
    begin
        chain_q <= chain;
    end

    // RotWord on the last column
    assign rot_word = {key_in[NUM_COLS-1][23:0], key_in[NUM_COLS-1][31:24]};

    aes_sbox_word sub_i (
        .clk      (clk),
        .word_in  (rot_word),
        .word_out (sub_word)
    );

    //////////////////////////////////////////////////////////////////////
    // Second cycle: finish the key
    //////////////////////////////////////////////////////////////////////

    // SubWord reaches every column through the chain
    always_comb
    begin
        for (int i = 0; i < NUM_COLS; i++)
        begin
            round_key[i] = chain_q[i] ^ sub_word;
        end
    end

    // Handed to the next stage with the next round's state
    always_ff @(posedge clk)
    begin
        next_key <= round_key;
    end

endmodule

// File: hdl/aes_pkg.sv
// AES-128 shared definitions
// Block and word types, pipeline depth, forward S-box, round constants
// and the GF(2^8) multiply-by-x helper

package aes_pkg;

    //////////////////////////////////////////////////////////////////////
    // Types and sizes
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_COLS     = 4;
    localparam int NUM_ROUNDS   = 10;
    localparam int ROUND_CYCLES = 2;

    // Input register plus two cycles per round
    localparam int LATENCY = 1 + NUM_ROUNDS * ROUND_CYCLES;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;

    // Column 0 sits in the top 32 bits, as in FIPS-197 byte order
    typedef word_t [0:NUM_COLS-1] block_t;

    //////////////////////////////////////////////////////////////////////
    // Tables
    //////////////////////////////////////////////////////////////////////

    // Forward S-box, row i holds entries 16*i to 16*i+15
    localparam byte_t SBOX [0:255] = '{
        'h63, 'h7c, 'h77, 'h7b, 'hf2, 'h6b, 'h6f, 'hc5, 'h30, 'h01, 'h67, 'h2b, 'hfe, 'hd7, 'hab, 'h76,
        'hca, 'h82, 'hc9, 'h7d, 'hfa, 'h59, 'h47, 'hf0, 'had, 'hd4, 'ha2, 'haf, 'h9c, 'ha4, 'h72, 'hc0,
        'hb7, 'hfd, 'h93, 'h26, 'h36, 'h3f, 'hf7, 'hcc, 'h34, 'ha5, 'he5, 'hf1, 'h71, 'hd8, 'h31, 'h15,
        'h04, 'hc7, 'h23, 'hc3, 'h18, 'h96, 'h05, 'h9a, 'h07, 'h12, 'h80, 'he2, 'heb, 'h27, 'hb2, 'h75,
        'h09, 'h83, 'h2c, 'h1a, 'h1b, 'h6e, 'h5a, 'ha0, 'h52, 'h3b, 'hd6, 'hb3, 'h29, 'he3, 'h2f, 'h84,
        'h53, 'hd1, 'h00, 'hed, 'h20, 'hfc, 'hb1, 'h5b, 'h6a, 'hcb, 'hbe, 'h39, 'h4a, 'h4c, 'h58, 'hcf,
        'hd0, 'hef, 'haa, 'hfb, 'h43, 'h4d, 'h33, 'h85, 'h45, 'hf9, 'h02, 'h7f, 'h50, 'h3c, 'h9f, 'ha8,
        'h51, 'ha3, 'h40, 'h8f, 'h92, 'h9d, 'h38, 'hf5, 'hbc, 'hb6, 'hda, 'h21, 'h10, 'hff, 'hf3, 'hd2,
        'hcd, 'h0c, 'h13, 'hec, 'h5f, 'h97, 'h44, 'h17, 'hc4, 'ha7, 'h7e, 'h3d, 'h64, 'h5d, 'h19, 'h73,
        'h60, 'h81, 'h4f, 'hdc, 'h22, 'h2a, 'h90, 'h88, 'h46, 'hee, 'hb8, 'h14, 'hde, 'h5e, 'h0b, 'hdb,
        'he0, 'h32, 'h3a, 'h0a, 'h49, 'h06, 'h24, 'h5c, 'hc2, 'hd3, 'hac, 'h62, 'h91, 'h95, 'he4, 'h79,
        'he7, 'hc8, 'h37, 'h6d, 'h8d, 'hd5, 'h4e, 'ha9, 'h6c, 'h56, 'hf4, 'hea, 'h65, 'h7a, 'hae, 'h08,
        'hba, 'h78, 'h25, 'h2e, 'h1c, 'ha6, 'hb4, 'hc6, 'he8, 'hdd, 'h74, 'h1f, 'h4b, 'hbd, 'h8b, 'h8a,
        'h70, 'h3e, 'hb5, 'h66, 'h48, 'h03, 'hf6, 'h0e, 'h61, 'h35, 'h57, 'hb9, 'h86, 'hc1, 'h1d, 'h9e,
        'he1, 'hf8, 'h98, 'h11, 'h69, 'hd9, 'h8e, 'h94, 'h9b, 'h1e, 'h87, 'he9, 'hce, 'h55, 'h28, 'hdf,
        'h8c, 'ha1, 'h89, 'h0d, 'hbf, 'he6, 'h42, 'h68, 'h41, 'h99, 'h2d, 'h0f, 'hb0, 'h54, 'hbb, 'h16
    };

    // Round constants, indexed by key schedule stage
    localparam byte_t RCON [0:NUM_ROUNDS-1] = '{
        'h01, 'h02, 'h04, 'h08, 'h10, 'h20, 'h40, 'h80, 'h1b, 'h36
    };

    //////////////////////////////////////////////////////////////////////
    // Field arithmetic
    //////////////////////////////////////////////////////////////////////

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(input byte_t b);
        byte_t shifted;
        shifted = {b[6:0], 1'b0};
        return b[7] ? (shifted ^ 8'h1b) : shifted;
    endfunction

endpackage

// File: hdl/aes_round.sv
// AES middle round
// SubBytes registered in the S-box, then ShiftRows, MixColumns and
// AddRoundKey into the output register, two cycles in all

`timescale 1ns/100ps

module aes_round
    import aes_pkg::*;
(
    input  logic   clk,
    input  block_t state_in,
    input  block_t round_key,
    output block_t state_out
);

    block_t sub_q;
    block_t mixed;

    // Registered SubBytes, one lookup per column
    for (genvar c = 0; c < NUM_COLS; c++)
    begin : g_sub
        aes_sbox_word sbox_i (
            .clk      (clk),
            .word_in  (state_in[c]),
            .word_out (sub_q[c])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // ShiftRows and MixColumns
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        byte_t col [0:3];
        for (int c = 0; c < NUM_COLS; c++)
        begin
            // Row r of column c comes from column c + r
            for (int r = 0; r < 4; r++)
            begin
                col[r] = sub_q[(c + r) % NUM_COLS][31 - 8 * r -: 8];
            end

            // 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3]
            for (int r = 0; r < 4; r++)
            begin
                mixed[c][31 - 8 * r -: 8] = xtime(col[r])
                                          ^ xtime(col[(r + 1) % 4])
                                          ^ col[(r + 1) % 4]
                                          ^ col[(r + 2) % 4]
                                          ^ col[(r + 3) % 4];
            end
        end
    end

    // AddRoundKey, key arrives combinationally from its stage
    always_ff @(posedge clk)
    begin
        state_out <= mixed ^ round_key;
    end

endmodule

// File: hdl/aes_sbox_word.sv
// AES S-box on one 32-bit word
// Four byte lookups in the forward S-box, registered together

`timescale 1ns/100ps

module aes_sbox_word
    import aes_pkg::*;
(
    input  logic  clk,
    input  word_t word_in,
    output word_t word_out
);

    byte_t sub_byte [0:3];

    // Table reads, byte 0 is the top byte of the word
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            sub_byte[i] = SBOX[word_in[31 - 8 * i -: 8]];
        end
    end

    // One pipeline register for the whole word
    always_ff @(posedge clk)
    begin
        word_out <= {sub_byte[0], sub_byte[1], sub_byte[2], sub_byte[3]};
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the AES-128 core testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_aes_128 -f sources.f -o sim_tb_aes_128
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/sim_tb_aes_128)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "=== PASS ===" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi

// File: sources.f
+incdir+tests
hdl/aes_pkg.sv
hdl/aes_sbox_word.sv
hdl/aes_key_stage.sv
hdl/aes_round.sv
hdl/aes_final_round.sv
hdl/aes_128_core.sv
tests/tb_aes_128.sv

// File: tests/tb_aes_model.svh
// Behavioral AES-128 reference and xorshift stimulus source
// Straight FIPS-197 byte-level encryption, included in the testbench

`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

logic [31:0] rng_state = 32'd46470;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic word_t rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

function automatic block_t rand_block();
    block_t blk;
    for (int i = 0; i < NUM_COLS; i++)
    begin
        blk[i] = rand_word();
    end
    return blk;
endfunction

// Byte n of a column, byte 0 on top
function automatic byte_t word_byte(input word_t w, input int n);
    return w[31 - 8 * n -: 8];
endfunction

// Multiply by 1, 2 or 3 in GF(2^8)
function automatic byte_t gf_mul(input byte_t b, input int m);
    if (m == 2)
        return xtime(b);
    else if (m == 3)
        return xtime(b) ^ b;
    return b;
endfunction

// Row of the MixColumns matrix is 2 3 1 1 rotated right by the row index
function automatic int mix_coef(input int d);
    return (d == 0) ? 2 : ((d == 1) ? 3 : 1);
endfunction

function automatic block_t aes_encrypt(input block_t pt, input block_t cipher_key);
    word_t  w [0:43];
    byte_t  s [0:15];
    byte_t  t [0:15];
    word_t  tmp;
    byte_t  acc;
    block_t res;

    // Full key expansion up front
    for (int i = 0; i < 4; i++)
    begin
        w[i] = cipher_key[i];
    end
    for (int i = 4; i < 44; i++)
    begin
        tmp = w[i-1];
        if (i % 4 == 0)
        begin
            tmp = {SBOX[tmp[23:16]], SBOX[tmp[15:8]], SBOX[tmp[7:0]], SBOX[tmp[31:24]]};
            tmp[31:24] = tmp[31:24] ^ RCON[i / 4 - 1];
        end
        w[i] = w[i-4] ^ tmp;
    end

    for (int i = 0; i < 16; i++)
    begin
        s[i] = word_byte(pt[i / 4], i % 4) ^ word_byte(w[i / 4], i % 4);
    end

    for (int rnd = 1; rnd <= NUM_ROUNDS; rnd++)
    begin
        // SubBytes and ShiftRows
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                t[4 * c + r] = SBOX[s[4 * ((c + r) % 4) + r]];
            end
        end
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                acc = t[4 * c + r];
                if (rnd < NUM_ROUNDS)
                begin
                    acc = '0;
                    for (int j = 0; j < 4; j++)
                    begin
                        acc = acc ^ gf_mul(t[4 * c + j], mix_coef((j - r + 4) % 4));
                    end
                end
                s[4 * c + r] = acc ^ word_byte(w[4 * rnd + c], r);
            end
        end
    end

    for (int i = 0; i < 16; i++)
    begin
        res[i / 4][31 - 8 * (i % 4) -: 8] = s[i];
    end
    return res;
endfunction

`endif

// File: tests/tb_aes_128.sv
// Testbench for the pipelined AES-128 core
// Known vectors, latency, throughput, bubbles and reset in flight

`timescale 1ns/100ps

module tb_aes_128
    import aes_pkg::*;
;

    localparam int RANDOM_BLOCKS = 64;
    localparam int BUBBLE_CYCLES = 48;
    localparam int RESET_PRE     = 30;
    localparam int RESET_POST    = 6;
    localparam int NUM_TESTS     = 5;
    localparam int DRAIN_LIMIT   = 2 * LATENCY;
    localparam int STIM_CYCLES   = 2 + 3 + 1 + RANDOM_BLOCKS + BUBBLE_CYCLES
                                 + RESET_PRE + 3 + LATENCY + RESET_POST;
    localparam int WATCHDOG_CYCLES = STIM_CYCLES + NUM_TESTS * DRAIN_LIMIT + 2 * LATENCY;

    logic   clk;
    logic   rst;
    logic   in_valid;
    block_t plaintext;
    block_t key;
    logic   out_valid;
    block_t ciphertext;

    block_t             exp_q [$];
    block_t             exp_cur;
    logic               exp_missing = 1'b0;
    logic [LATENCY-1:0] valid_hist  = '0;
    logic               valid_due;
    logic               valid_seen;
    block_t             ct_seen;
    int                 error_count = 0;
    int                 pass_count  = 0;
    int                 fail_count  = 0;

    `include "tb_aes_model.svh"

    aes_128_core dut_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .ciphertext (ciphertext)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference for the valid bit and the expected result
    //////////////////////////////////////////////////////////////////////

    // History of in_valid, cleared by reset
    always @(posedge clk)
    begin
        if (rst)
            valid_hist <= '0;
        else
            valid_hist <= {valid_hist[LATENCY-2:0], in_valid};
    end

    // Mid-cycle capture of the outputs and the expected result
    always @(negedge clk)
    begin
        valid_seen = out_valid;
        ct_seen    = ciphertext;
        valid_due  = valid_hist[LATENCY-1];
        if (out_valid === 1'b1)
        begin
            if (exp_q.size() > 0)
            begin
                exp_cur     = exp_q.pop_front();
                exp_missing = 1'b0;
            end
            else
                exp_missing = 1'b1;
        end
    end

    a_out_valid_latency: assert property (
        @(posedge clk) disable iff (rst) out_valid == valid_hist[LATENCY-1]
    ) else begin
        error_count++;
        $display("[ERROR] %0t out_valid expected %b got %b", $time, valid_due, valid_seen);
    end

    // Reset empties the pipe on the following cycle
    a_reset_clears_valid: assert property (
        @(posedge clk) rst |=> !out_valid
    ) else begin
        error_count++;
        $display("[ERROR] %0t out_valid expected %b got %b", $time, 1'b0, valid_seen);
    end

    a_result_expected: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> !exp_missing
    ) else begin
        error_count++;
        $display("At %0t a result came out with no block outstanding", $time);
    end

    a_ciphertext_match: assert property (
        @(posedge clk) disable iff (rst) (out_valid && !exp_missing) |-> ciphertext == exp_cur
    ) else begin
        error_count++;
        $display("[ERROR] %0t ciphertext expected %h got %h", $time, exp_cur, ct_seen);
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic drive_block(input logic v, input block_t pt, input block_t k,
                               input block_t expected);
        @(posedge clk);
        #2;
        in_valid  = v;
        plaintext = pt;
        key       = k;
        if (v)
            exp_q.push_back(expected);
    endtask

    task automatic send_vector(input block_t vec_key, input block_t vec_pt,
                               input block_t vec_ct);
        if (aes_encrypt(vec_pt, vec_key) !== vec_ct)
        begin
            error_count++;
            $display("Reference model disagrees with the vector for key %h", vec_key);
        end
        drive_block(1'b1, vec_pt, vec_key, vec_ct);
    endtask

    task automatic send_random(input logic v);
        block_t pt;
        block_t k;
        pt = rand_block();
        k  = rand_block();
        drive_block(v, pt, k, aes_encrypt(pt, k));
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        #2;
        rst      = 1'b1;
        in_valid = 1'b0;
        exp_q.delete();
        repeat (cycles) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    // Idle until every expected result has come out
    task automatic drain_results();
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        while ((exp_q.size() != 0 || out_valid) && waited < DRAIN_LIMIT)
        begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            error_count++;
            $display("%0d expected results never came out of the pipeline", exp_q.size());
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        int errs;
        errs = error_count - start_errors;
        if (errs == 0)
            pass_count++;
        else
            fail_count++;
        $display("Test %-16s %s, %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
    endtask

    initial
    begin
        int start_errors;
        logic [31:0] r;

        rst       = 1'b1;
        in_valid  = 1'b0;
        plaintext = '0;
        key       = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        start_errors = error_count;
        send_vector(128'h000102030405060708090a0b0c0d0e0f,
                    128'h00112233445566778899aabbccddeeff,
                    128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        send_vector(128'h2b7e151628aed2a6abf7158809cf4f3c,
                    128'h3243f6a8885a308d313198a2e0370734,
                    128'h3925841d02dc09fbdc118597196a0b32);
        send_vector('0, '0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e);
        drain_results();
        finish_test("known_vectors", start_errors);

        start_errors = error_count;
        send_random(1'b1);
        drain_results();
        finish_test("fixed_latency", start_errors);

        start_errors = error_count;
        for (int i = 0; i < RANDOM_BLOCKS; i++)
        begin
            send_random(1'b1);
        end
        drain_results();
        finish_test("full_throughput", start_errors);

        // Roughly one cycle in four left empty
        start_errors = error_count;
        for (int i = 0; i < BUBBLE_CYCLES; i++)
        begin
            r = rand_word();
            send_random(r[1:0] != 2'b00);
        end
        drain_results();
        finish_test("bubbles", start_errors);

        // Results already leaving when reset hits
        start_errors = error_count;
        for (int i = 0; i < RESET_PRE; i++)
        begin
            send_random(1'b1);
        end
        apply_reset(2);
        repeat (LATENCY) @(posedge clk);
        for (int i = 0; i < RESET_POST; i++)
        begin
            send_random(1'b1);
        end
        drain_results();
        finish_test("reset_in_flight", start_errors);

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
